//--- upd_settings.svh
`ifndef UPD_SETTINGS_SVH
`define UPD_SETTINGS_SVH

// Datapath widths
`define UPD_DATA_W      8
`define UPD_TM_W        12
`define UPD_PRESCALE_W  3

// INT1/INT2 sampling
`define UPD_TICK_DIV    12
`define UPD_FILTER_LEN  4

// Values loaded by reset
`define UPD_MK_RESET    8'hFF
`define UPD_MODE_RESET  8'hFF

// Interrupt vector addresses
`define UPD_VEC_INT0    8'h04
`define UPD_VEC_INTT    8'h08
`define UPD_VEC_INT1    8'h10
`define UPD_VEC_INT2    8'h20

`endif

//--- upd_spr_pkg.sv
`include "upd_settings.svh"

package upd_spr_pkg;

  // Special register select, same order as the on-chip SPR decode
  typedef enum logic [3:0] {
    SEL_PA  = 4'd0,
    SEL_PB  = 4'd1,
    SEL_PC  = 4'd2,
    SEL_MK  = 4'd3,
    SEL_MB  = 4'd4,
    SEL_MC  = 4'd5,
    SEL_TM0 = 4'd6,
    SEL_TM1 = 4'd7,
    SEL_IE  = 4'd8
  } spr_sel_e;

  typedef enum logic [1:0] {
    OP_READ        = 2'd0,
    OP_WRITE       = 2'd1,
    OP_TIMER_START = 2'd2
  } spr_op_e;

  typedef struct packed {
    spr_op_e                op;
    spr_sel_e               sel;
    logic [`UPD_DATA_W-1:0] wdata;
  } spr_req_t;

  typedef struct packed {
    logic [`UPD_DATA_W-1:0] rdata;
  } spr_rsp_t;

  // Single-cycle register write
  typedef struct packed {
    logic                   valid;
    spr_sel_e               sel;
    logic [`UPD_DATA_W-1:0] data;
  } spr_wr_t;

endpackage

//--- upd_int_pkg.sv
`include "upd_settings.svh"

package upd_int_pkg;

  // Source index, lowest value has highest priority
  typedef enum logic [1:0] {
    SRC_INT0 = 2'd0,
    SRC_INTT = 2'd1,
    SRC_INT1 = 2'd2,
    SRC_INT2 = 2'd3
  } int_src_e;

  typedef struct packed {
    int_src_e               src;
    logic [`UPD_DATA_W-1:0] addr;
  } int_vec_t;

endpackage

//--- spr_bus_port.sv
`include "upd_settings.svh"

module spr_bus_port import upd_spr_pkg::*; (
  input  logic                   CLK,
  input  logic                   rst,
  input  logic                   host_req,
  input  spr_req_t               host_cmd,
  output logic                   host_ack,
  output spr_rsp_t               host_rsp,
  output spr_wr_t                wr,
  output logic                   timer_start,
  output spr_sel_e               sel,
  input  logic [`UPD_DATA_W-1:0] port_rd,
  input  logic [`UPD_DATA_W-1:0] timer_rd,
  input  logic [`UPD_DATA_W-1:0] intc_rd
);

  logic                   accept;
  logic [`UPD_DATA_W-1:0] rd_merged;

  // New command only once the previous handshake has fully closed
  assign accept = host_req & ~host_ack;

  assign sel = host_cmd.sel;

  // Units not owning the select return zero
  assign rd_merged = port_rd | timer_rd | intc_rd;

  // Strobes land on the same edge that raises host_ack
  assign wr.valid    = accept & (host_cmd.op == OP_WRITE);
  assign wr.sel      = host_cmd.sel;
  assign wr.data     = host_cmd.wdata;
  assign timer_start = accept & (host_cmd.op == OP_TIMER_START);

  always_ff @(posedge CLK) begin
    if (rst) begin
      host_ack <= 1'b0;
    end else if (accept) begin
      host_ack <= 1'b1;
    end else if (!host_req) begin
      host_ack <= 1'b0;
    end
  end

  // Held for the whole acknowledge phase
  always_ff @(posedge CLK) begin
    if (accept && host_cmd.op == OP_READ) begin
      host_rsp.rdata <= rd_merged;
    end
  end

  // Acknowledge only answers a request seen on the previous edge
  assert property (@(posedge CLK) disable iff (rst)
    $rose(host_ack) |-> $past(host_req));

  // One write strobe per handshake
  assert property (@(posedge CLK) disable iff (rst)
    wr.valid |=> !wr.valid);

endmodule

//--- int_sampler.sv
`include "upd_settings.svh"

module int_sampler (
  input  logic CLK,
  input  logic rst,
  input  logic int0,
  input  logic int1,
  input  logic int2,
  input  logic int2_polarity,
  output logic int0_level,
  output logic int1_event,
  output logic int2_event
);

  localparam int CNT_W = $clog2(`UPD_TICK_DIV);
  localparam int LEN   = `UPD_FILTER_LEN;

  // One low sample followed by LEN-1 high samples
  localparam logic [LEN-1:0] EDGE_PAT = {1'b0, {(LEN - 1){1'b1}}};

  logic [CNT_W-1:0]      tick_cnt;
  logic                  tick;
  logic [1:0]            raw_in;
  logic [1:0][LEN-1:0]   filt;

  assign tick = (tick_cnt == CNT_W'(`UPD_TICK_DIV - 1));

  always_ff @(posedge CLK) begin
    if (rst) begin
      tick_cnt <= '0;
    end else begin
      tick_cnt <= tick ? '0 : tick_cnt + 1'b1;
    end
  end

  // Falling-edge mode for INT2 is handled by inverting the pin
  assign raw_in = {int2 ^ ~int2_polarity, int1};

  always_ff @(posedge CLK) begin
    if (rst) begin
      filt       <= '1;
      int1_event <= 1'b0;
      int2_event <= 1'b0;
    end else begin
      int1_event <= tick & ({filt[0][LEN-2:0], raw_in[0]} == EDGE_PAT);
      int2_event <= tick & ({filt[1][LEN-2:0], raw_in[1]} == EDGE_PAT);
      if (tick) begin
        for (int i = 0; i < 2; i++) begin
          filt[i] <= {filt[i][LEN-2:0], raw_in[i]};
        end
      end
    end
  end

  // INT0 is level sensitive, synchronised only
  always_ff @(posedge CLK) begin
    if (rst) begin
      int0_level <= 1'b0;
    end else begin
      int0_level <= int0;
    end
  end

endmodule

//--- timer_unit.sv
`include "upd_settings.svh"

module timer_unit import upd_spr_pkg::*; (
  input  logic                   CLK,
  input  logic                   rst,
  input  spr_wr_t                wr,
  input  logic                   timer_start,
  input  spr_sel_e               sel,
  output logic [`UPD_DATA_W-1:0] rd_data,
  output logic                   tm_underflow
);

  localparam int DW    = `UPD_DATA_W;
  localparam int HI_W  = `UPD_TM_W - `UPD_DATA_W;
  localparam int CNT_W = `UPD_TM_W + `UPD_PRESCALE_W;

  logic [`UPD_TM_W-1:0] tm;
  // Low bits act as the divide-by-8 prescaler
  logic [CNT_W-1:0]     tc;

  always_ff @(posedge CLK) begin
    if (rst) begin
      tm <= '1;
    end else if (wr.valid) begin
      case (wr.sel)
        SEL_TM0: tm[DW-1:0] <= wr.data;
        SEL_TM1: tm[`UPD_TM_W-1:DW] <= wr.data[HI_W-1:0];
        default: ;
      endcase
    end
  end

  assign tm_underflow = (tc == '0);

  // Reload restarts the prescaler as well
  always_ff @(posedge CLK) begin
    if (rst) begin
      tc <= '1;
    end else if (tm_underflow || timer_start) begin
      tc <= {tm, {`UPD_PRESCALE_W{1'b1}}};
    end else begin
      tc <= tc - 1'b1;
    end
  end

  always_comb begin
    case (sel)
      SEL_TM0: rd_data = tm[DW-1:0];
      SEL_TM1: rd_data = {{(DW - HI_W){1'b0}}, tm[`UPD_TM_W-1:DW]};
      default: rd_data = '0;
    endcase
  end

endmodule

//--- int_controller.sv
`include "upd_settings.svh"

module int_controller
  import upd_spr_pkg::*;
  import upd_int_pkg::*;
(
  input  logic                   CLK,
  input  logic                   rst,
  input  spr_wr_t                wr,
  input  spr_sel_e               sel,
  output logic [`UPD_DATA_W-1:0] rd_data,
  input  logic                   int0_level,
  input  logic                   int1_event,
  input  logic                   int2_event,
  input  logic                   tm_underflow,
  output logic                   int2_polarity,
  output logic                   int_req,
  output int_vec_t               int_vector,
  input  logic                   int_ack
);

  typedef enum logic {
    ST_IDLE,
    ST_REQ
  } hs_state_e;

  hs_state_e              state;
  logic [`UPD_DATA_W-1:0] mk;
  logic [`UPD_DATA_W-1:0] ie;
  logic [3:0]             pend;
  logic [3:0]             active;
  logic                   start_req;
  logic                   ack_take;
  int_src_e               pick;

  function automatic logic [`UPD_DATA_W-1:0] vec_addr(input int_src_e src);
    case (src)
      SRC_INT0: vec_addr = `UPD_VEC_INT0;
      SRC_INTT: vec_addr = `UPD_VEC_INTT;
      SRC_INT1: vec_addr = `UPD_VEC_INT1;
      default:  vec_addr = `UPD_VEC_INT2;
    endcase
  endfunction

  ////////////////////////////////////////
  // Mask and enable registers

  always_ff @(posedge CLK) begin
    if (rst) begin
      mk <= `UPD_MK_RESET;
      ie <= '0;
    end else if (wr.valid) begin
      case (wr.sel)
        SEL_MK:  mk <= wr.data;
        SEL_IE:  ie <= wr.data;
        default: ;
      endcase
    end
  end

  // Bit 5 picks the INT2 edge, bits 4 and 6-7 are storage only
  assign int2_polarity = mk[5];

  always_comb begin
    case (sel)
      SEL_MK:  rd_data = mk;
      SEL_IE:  rd_data = ie;
      default: rd_data = '0;
    endcase
  end

  ////////////////////////////////////////
  // Pending bits and priority

  assign ack_take = (state == ST_REQ) & int_ack;

  always_ff @(posedge CLK) begin
    if (rst) begin
      pend <= '0;
    end else begin
      if (ack_take) begin
        pend[int_vector.src] <= 1'b0;
      end
      pend[SRC_INT0] <= int0_level;
      if (tm_underflow) pend[SRC_INTT] <= 1'b1;
      if (int1_event)   pend[SRC_INT1] <= 1'b1;
      if (int2_event)   pend[SRC_INT2] <= 1'b1;
    end
  end

  assign active = pend & {4{ie[0]}} & ~mk[3:0];

  // Lowest index wins
  always_comb begin
    pick = SRC_INT0;
    for (int i = 3; i >= 0; i--) begin
      if (active[i]) pick = int_src_e'(i);
    end
  end

  ////////////////////////////////////////
  // Vector handshake

  assign start_req = (state == ST_IDLE) & (|active) & ~int_ack;

  always_ff @(posedge CLK) begin
    if (rst) begin
      state <= ST_IDLE;
    end else if (start_req) begin
      state <= ST_REQ;
    end else if (ack_take) begin
      state <= ST_IDLE;
    end
  end

  always_ff @(posedge CLK) begin
    if (start_req) begin
      int_vector.src  <= pick;
      int_vector.addr <= vec_addr(pick);
    end
  end

  assign int_req = (state == ST_REQ);

  // Master may sample the vector at any point of the request
  assert property (@(posedge CLK) disable iff (rst)
    int_req && $past(int_req) |-> $stable(int_vector));

endmodule

//--- port_unit.sv
`include "upd_settings.svh"

module port_unit import upd_spr_pkg::*; (
  input  logic                   CLK,
  input  logic                   rst,
  input  spr_wr_t                wr,
  input  spr_sel_e               sel,
  output logic [`UPD_DATA_W-1:0] rd_data,
  output logic [`UPD_DATA_W-1:0] pa_o,
  input  logic [`UPD_DATA_W-1:0] pb_i,
  output logic [`UPD_DATA_W-1:0] pb_o,
  output logic [`UPD_DATA_W-1:0] pb_oe,
  input  logic [`UPD_DATA_W-1:0] pc_i,
  output logic [`UPD_DATA_W-1:0] pc_o,
  output logic [`UPD_DATA_W-1:0] pc_oe
);

  localparam int DW = `UPD_DATA_W;

  logic [DW-1:0] mb;
  logic [DW-1:0] mc;

  // Driven bits from the latch, input bits from the pin
  function automatic logic [DW-1:0] pin_merge(input logic [DW-1:0] out_q,
                                              input logic [DW-1:0] pin,
                                              input logic [DW-1:0] oe);
    pin_merge = (out_q & oe) | (pin & ~oe);
  endfunction

  always_ff @(posedge CLK) begin
    if (rst) begin
      pa_o <= '0;
      pb_o <= '0;
      pc_o <= '0;
      mb   <= `UPD_MODE_RESET;
      mc   <= `UPD_MODE_RESET;
    end else if (wr.valid) begin
      case (wr.sel)
        SEL_PA:  pa_o <= wr.data;
        SEL_PB:  pb_o <= wr.data;
        SEL_PC:  pc_o <= wr.data;
        SEL_MB:  mb   <= wr.data;
        SEL_MC:  mc   <= wr.data;
        default: ;
      endcase
    end
  end

  // Mode bit 1 means input
  assign pb_oe = ~mb;
  // PC6-PC3 always drive, PC2 always input
  assign pc_oe = {~mc[7], 4'b1111, 1'b0, ~mc[1:0]};

  always_comb begin
    case (sel)
      SEL_PA:  rd_data = pa_o;
      SEL_PB:  rd_data = pin_merge(pb_o, pb_i, pb_oe);
      SEL_PC:  rd_data = pin_merge(pc_o, pc_i, pc_oe);
      SEL_MB:  rd_data = mb;
      SEL_MC:  rd_data = mc;
      default: rd_data = '0;
    endcase
  end

endmodule

//--- upd_periph_top.sv
`include "upd_settings.svh"

module upd_periph_top
  import upd_spr_pkg::*;
  import upd_int_pkg::*;
(
  input  logic                   CLK,
  input  logic                   rst,
  input  logic                   host_req,
  input  spr_req_t               host_cmd,
  output logic                   host_ack,
  output spr_rsp_t               host_rsp,
  input  logic                   int0,
  input  logic                   int1,
  input  logic                   int2,
  output logic                   int_req,
  output int_vec_t               int_vector,
  input  logic                   int_ack,
  output logic [`UPD_DATA_W-1:0] pa_o,
  input  logic [`UPD_DATA_W-1:0] pb_i,
  output logic [`UPD_DATA_W-1:0] pb_o,
  output logic [`UPD_DATA_W-1:0] pb_oe,
  input  logic [`UPD_DATA_W-1:0] pc_i,
  output logic [`UPD_DATA_W-1:0] pc_o,
  output logic [`UPD_DATA_W-1:0] pc_oe
);

  spr_wr_t                wr;
  spr_sel_e               sel;
  logic                   timer_start;
  logic [`UPD_DATA_W-1:0] port_rd;
  logic [`UPD_DATA_W-1:0] timer_rd;
  logic [`UPD_DATA_W-1:0] intc_rd;
  logic                   int0_level;
  logic                   int1_event;
  logic                   int2_event;
  logic                   tm_underflow;
  logic                   int2_polarity;

  ////////////////////////////////////////
  // Input side

  spr_bus_port u_bus (
    .CLK         (CLK),
    .rst         (rst),
    .host_req    (host_req),
    .host_cmd    (host_cmd),
    .host_ack    (host_ack),
    .host_rsp    (host_rsp),
    .wr          (wr),
    .timer_start (timer_start),
    .sel         (sel),
    .port_rd     (port_rd),
    .timer_rd    (timer_rd),
    .intc_rd     (intc_rd)
  );

  int_sampler u_sampler (
    .CLK           (CLK),
    .rst           (rst),
    .int0          (int0),
    .int1          (int1),
    .int2          (int2),
    .int2_polarity (int2_polarity),
    .int0_level    (int0_level),
    .int1_event    (int1_event),
    .int2_event    (int2_event)
  );

  ////////////////////////////////////////
  // Timer and interrupt logic

  timer_unit u_timer (
    .CLK          (CLK),
    .rst          (rst),
    .wr           (wr),
    .timer_start  (timer_start),
    .sel          (sel),
    .rd_data      (timer_rd),
    .tm_underflow (tm_underflow)
  );

  int_controller u_intc (
    .CLK           (CLK),
    .rst           (rst),
    .wr            (wr),
    .sel           (sel),
    .rd_data       (intc_rd),
    .int0_level    (int0_level),
    .int1_event    (int1_event),
    .int2_event    (int2_event),
    .tm_underflow  (tm_underflow),
    .int2_polarity (int2_polarity),
    .int_req       (int_req),
    .int_vector    (int_vector),
    .int_ack       (int_ack)
  );

  ////////////////////////////////////////
  // Output side

  port_unit u_port (
    .CLK     (CLK),
    .rst     (rst),
    .wr      (wr),
    .sel     (sel),
    .rd_data (port_rd),
    .pa_o    (pa_o),
    .pb_i    (pb_i),
    .pb_o    (pb_o),
    .pb_oe   (pb_oe),
    .pc_i    (pc_i),
    .pc_o    (pc_o),
    .pc_oe   (pc_oe)
  );

endmodule

//--- tb_checker.sv
module tb_checker
  import upd_spr_pkg::*;
  import upd_int_pkg::*;
(
  input logic       CLK,
  input logic       rst,
  input logic       host_ack,
  input spr_rsp_t   host_rsp,
  input logic       int_req,
  input int_vec_t   int_vector,
  input logic [7:0] pa_o,
  input logic [7:0] pb_o,
  input logic [7:0] pb_oe,
  input logic [7:0] pc_o,
  input logic [7:0] pc_oe
);
  timeunit 1ns;
  timeprecision 100ps;

  int          checks = 0;
  int          errors = 0;

  // Expectations posted by the stimulus loop
  bit          read_armed = 1'b0;
  logic [7:0]  read_exp;
  string       read_name;
  bit          vec_armed = 1'b0;
  int_vec_t    vec_exp;
  string       vec_name;
  bit          oe_armed = 1'b0;
  logic [15:0] oe_exp;
  string       oe_name;
  bit          out_armed = 1'b0;
  logic [23:0] out_exp;
  string       out_name;
  bit          quiet = 1'b0;
  string       quiet_name;

  function void await_read(input string name, input logic [7:0] value);
    read_name  = name;
    read_exp   = value;
    read_armed = 1'b1;
  endfunction

  function void await_vector(input string name, input int_vec_t value);
    vec_name  = name;
    vec_exp   = value;
    vec_armed = 1'b1;
  endfunction

  function void check_enables_next(input string name, input logic [15:0] value);
    oe_name  = name;
    oe_exp   = value;
    oe_armed = 1'b1;
  endfunction

  // Port output registers as {pa_o, pb_o, pc_o}
  function void check_outputs_next(input string name, input logic [23:0] value);
    out_name  = name;
    out_exp   = value;
    out_armed = 1'b1;
  endfunction

  // Any request inside this window is an error
  function void forbid_requests(input string name);
    quiet_name = name;
    quiet      = 1'b1;
    checks++;
  endfunction

  function void allow_requests();
    quiet = 1'b0;
  endfunction

  function void note_timeout(input string msg);
    errors++;
    $display("Timeout in %s", msg);
  endfunction

  function void compare_value(input string name, input logic [15:0] exp_v,
                              input logic [15:0] act_v);
    checks++;
    if (act_v !== exp_v) begin
      errors++;
      $display("Fail %s: expected 0x%0h, actual 0x%0h", name, exp_v, act_v);
    end
  endfunction

  ////////////////////////////////////////
  // Sampling mid-cycle, away from the edges

  always @(negedge CLK) begin
    if (!rst) begin
      if (read_armed && host_ack) begin
        compare_value(read_name, {8'h00, read_exp}, {8'h00, host_rsp.rdata});
        read_armed = 1'b0;
      end
      if (vec_armed && int_req) begin
        compare_value(vec_name, {6'b0, vec_exp}, {6'b0, int_vector});
        vec_armed = 1'b0;
      end
      if (oe_armed) begin
        compare_value(oe_name, oe_exp, {pb_oe, pc_oe});
        oe_armed = 1'b0;
      end
      if (out_armed) begin
        compare_value({out_name, " pa_o"}, {8'h00, out_exp[23:16]}, {8'h00, pa_o});
        compare_value({out_name, " pb_o/pc_o"}, out_exp[15:0], {pb_o, pc_o});
        out_armed = 1'b0;
      end
      if (quiet && int_req) begin
        errors++;
        $display("Interrupt request raised during %s, vector 0x%0h", quiet_name, int_vector);
        quiet = 1'b0;
      end
    end
  end

endmodule

//--- tb_upd_periph.sv
module tb_upd_periph
  import upd_spr_pkg::*;
  import upd_int_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  typedef enum logic [2:0] {
    K_HOST,
    K_PINS,
    K_QUIET,
    K_OE,
    K_OUT,
    K_VEC
  } step_kind_e;

  typedef struct packed {
    logic       int0;
    logic       int1;
    logic       int2;
    logic [7:0] pb;
    logic [7:0] pc;
  } pins_t;

  // exp_val holds read data, {pb_oe, pc_oe}, {pa_o, pb_o, pc_o} or the vector
  typedef struct packed {
    step_kind_e  kind;
    spr_req_t    cmd;
    pins_t       pins;
    logic [23:0] exp_val;
    logic [7:0]  cycles;
  } step_t;

  logic       CLK;
  logic       rst;
  logic       host_req;
  spr_req_t   host_cmd;
  logic       host_ack;
  spr_rsp_t   host_rsp;
  logic       int0;
  logic       int1;
  logic       int2;
  logic       int_req;
  int_vec_t   int_vector;
  logic       int_ack;
  logic [7:0] pa_o;
  logic [7:0] pb_i;
  logic [7:0] pb_o;
  logic [7:0] pb_oe;
  logic [7:0] pc_i;
  logic [7:0] pc_o;
  logic [7:0] pc_oe;

  step_t      steps[$];
  string      names[$];
  pins_t      cur;
  int         seed = 44056;

  upd_periph_top uut (.*);

  tb_checker chk (.*);

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  ////////////////////////////////////////
  // Table construction

  function void add_step(input string name, input step_kind_e kind, input spr_req_t cmd,
                         input logic [23:0] exp_val, input logic [7:0] cycles);
    step_t s;
    s.kind    = kind;
    s.cmd     = cmd;
    s.pins    = cur;
    s.exp_val = exp_val;
    s.cycles  = cycles;
    steps.push_back(s);
    names.push_back(name);
  endfunction

  function void add_write(input string name, input spr_sel_e sel, input logic [7:0] data);
    add_step(name, K_HOST, spr_req_t'{op: OP_WRITE, sel: sel, wdata: data}, 24'h0, 8'd0);
  endfunction

  function void add_read(input string name, input spr_sel_e sel, input logic [7:0] exp_rd);
    add_step(name, K_HOST, spr_req_t'{op: OP_READ, sel: sel, wdata: 8'h00},
             {16'h0000, exp_rd}, 8'd0);
  endfunction

  function void add_vector(input string name, input int_src_e src, input logic [7:0] addr,
                           input logic [7:0] limit);
    add_step(name, K_VEC, '0, {14'b0, src, addr}, limit);
  endfunction

  task automatic build_table();
    logic [7:0] r;
    logic [7:0] mb_v;
    logic [7:0] mc_v;
    logic [7:0] pa_v;
    logic [7:0] pb_v;
    logic [7:0] pc_v;
    logic [7:0] pc_drv;
    // INT2 idles high so the rising-edge filter never sees a low sample
    cur = '{int0: 1'b0, int1: 1'b0, int2: 1'b1, pb: 8'h00, pc: 8'h00};
    add_read("PA reset", SEL_PA, 8'h00);
    add_read("MK reset", SEL_MK, 8'hFF);
    add_read("MB reset", SEL_MB, 8'hFF);
    add_read("MC reset", SEL_MC, 8'hFF);
    add_read("TM0 reset", SEL_TM0, 8'hFF);
    add_read("TM1 reset", SEL_TM1, 8'h0F);
    add_read("IE reset", SEL_IE, 8'h00);

    // Write and read back
    r = 8'($random(seed));
    add_write("PA write", SEL_PA, r);
    add_read("PA readback", SEL_PA, r);
    // MK bit 5 stays set, INT2 polarity unchanged
    r = 8'($random(seed)) | 8'h20;
    add_write("MK write", SEL_MK, r);
    add_read("MK readback", SEL_MK, r);
    r = 8'($random(seed));
    add_write("MB write", SEL_MB, r);
    add_read("MB readback", SEL_MB, r);
    r = 8'($random(seed));
    add_write("MC write", SEL_MC, r);
    add_read("MC readback", SEL_MC, r);
    r = 8'($random(seed));
    add_write("TM0 write", SEL_TM0, r);
    add_read("TM0 readback", SEL_TM0, r);
    r = 8'($random(seed));
    add_write("TM1 write", SEL_TM1, r);
    add_read("TM1 readback", SEL_TM1, r & 8'h0F);
    r = 8'($random(seed));
    add_write("IE write", SEL_IE, r);
    add_read("IE readback", SEL_IE, r);

    // Port direction and pin merge
    for (int i = 0; i < 2; i++) begin
      mb_v   = 8'($random(seed));
      mc_v   = 8'($random(seed));
      pa_v   = 8'($random(seed));
      pb_v   = 8'($random(seed));
      pc_v   = 8'($random(seed));
      cur.pb = 8'($random(seed));
      cur.pc = 8'($random(seed));
      pc_drv = {~mc_v[7], 4'b1111, 1'b0, ~mc_v[1:0]};
      add_write("MB random", SEL_MB, mb_v);
      add_write("MC random", SEL_MC, mc_v);
      add_write("PA random", SEL_PA, pa_v);
      add_write("PB random", SEL_PB, pb_v);
      add_write("PC random", SEL_PC, pc_v);
      add_step("port outputs", K_OUT, '0, {pa_v, pb_v, pc_v}, 8'd1);
      add_step("pb_oe/pc_oe", K_OE, '0, {8'h00, ~mb_v, pc_drv}, 8'd1);
      add_read("PB merge", SEL_PB, (pb_v & ~mb_v) | (cur.pb & mb_v));
      add_read("PC merge", SEL_PC, (pc_v & pc_drv) | (cur.pc & ~pc_drv));
    end

    // INT1 edge filter
    add_write("IE on", SEL_IE, 8'h01);
    add_write("MK unmask INT1", SEL_MK, 8'hFB);
    cur.int1 = 1'b1;
    add_step("INT1 held high", K_PINS, '0, 24'h0, 8'd60);
    cur.int1 = 1'b0;
    add_vector("INT1 vector", SRC_INT1, 8'h10, 8'd40);
    add_step("INT1 low", K_PINS, '0, 24'h0, 8'd40);
    cur.int1 = 1'b1;
    add_step("INT1 short pulse", K_QUIET, '0, 24'h0, 8'd20);
    cur.int1 = 1'b0;
    add_step("INT1 after pulse", K_QUIET, '0, 24'h0, 8'd80);

    // Mask and priority
    add_write("IE off", SEL_IE, 8'h00);
    add_write("MK unmask INT0 INT1", SEL_MK, 8'hFA);
    cur.int0 = 1'b1;
    cur.int1 = 1'b1;
    add_step("INT1 edge with IE off", K_QUIET, '0, 24'h0, 8'd60);
    cur.int1 = 1'b0;
    add_step("INT0 high with IE off", K_QUIET, '0, 24'h0, 8'd40);
    add_write("IE on again", SEL_IE, 8'h01);
    // INT0 is released once its request is up
    cur.int0 = 1'b0;
    add_vector("INT0 vector first", SRC_INT0, 8'h04, 8'd20);
    add_vector("INT1 vector second", SRC_INT1, 8'h10, 8'd20);

    // INT2 on the falling edge
    add_write("MK INT2 falling", SEL_MK, 8'hD7);
    add_step("INT2 polarity settle", K_QUIET, '0, 24'h0, 8'd50);
    cur.int2 = 1'b0;
    add_step("INT2 falls", K_PINS, '0, 24'h0, 8'd1);
    add_vector("INT2 vector", SRC_INT2, 8'h20, 8'd80);

    // Interval timer, underflow every 32 cycles
    add_write("TM0 load", SEL_TM0, 8'h03);
    add_write("TM1 load", SEL_TM1, 8'h00);
    add_step("timer start", K_HOST, spr_req_t'{op: OP_TIMER_START, sel: SEL_TM0, wdata: 8'h00},
             24'h0, 8'd0);
    add_write("MK unmask INTT", SEL_MK, 8'hFD);
    add_vector("INTT first", SRC_INTT, 8'h08, 8'd40);
    add_vector("INTT second", SRC_INTT, 8'h08, 8'd40);
  endtask

  ////////////////////////////////////////
  // Drivers

  task automatic next_cycle();
    @(posedge CLK);
    #1;
  endtask

  task automatic apply_pins(input pins_t p);
    int0 = p.int0;
    int1 = p.int1;
    int2 = p.int2;
    pb_i = p.pb;
    pc_i = p.pc;
  endtask

  task automatic wait_for(input bit on_int, input logic level, input int limit,
                          input string name, output bit ok);
    int    n;
    string sig;
    ok  = 1'b0;
    n   = 0;
    sig = on_int ? "int_req" : "host_ack";
    while (!ok && n < limit) begin
      next_cycle();
      ok = ((on_int ? int_req : host_ack) == level);
      n++;
    end
    if (!ok) begin
      chk.note_timeout($sformatf("%s: %s did not %s within %0d cycles", name, sig,
                                 level ? "rise" : "fall", limit));
    end
  endtask

  task automatic host_access(input spr_req_t cmd, input logic [7:0] exp_rd,
                             input string name, output bit ok);
    if (cmd.op == OP_READ) begin
      chk.await_read(name, exp_rd);
    end
    host_cmd = cmd;
    host_req = 1'b1;
    wait_for(1'b0, 1'b1, 10, name, ok);
    host_req = 1'b0;
    if (ok) begin
      wait_for(1'b0, 1'b0, 10, name, ok);
    end
  endtask

  task automatic vector_ack(input step_t s, input string name, output bit ok);
    chk.await_vector(name, int_vec_t'(s.exp_val[9:0]));
    wait_for(1'b1, 1'b1, int'(s.cycles), name, ok);
    if (ok) begin
      apply_pins(s.pins);
      repeat (3) next_cycle();
      int_ack = 1'b1;
      wait_for(1'b1, 1'b0, 10, name, ok);
      int_ack = 1'b0;
    end
  endtask

  // Pins go out first, except for a vector step where they follow the request
  task automatic run_step(input step_t s, input string name, output bit ok);
    ok = 1'b1;
    if (s.kind != K_VEC) begin
      apply_pins(s.pins);
    end
    case (s.kind)
      K_HOST: host_access(s.cmd, s.exp_val[7:0], name, ok);
      K_PINS: repeat (s.cycles) next_cycle();
      K_QUIET: begin
        chk.forbid_requests(name);
        repeat (s.cycles) next_cycle();
        chk.allow_requests();
      end
      K_OE: begin
        chk.check_enables_next(name, s.exp_val[15:0]);
        next_cycle();
      end
      K_OUT: begin
        chk.check_outputs_next(name, s.exp_val);
        next_cycle();
      end
      default: vector_ack(s, name, ok);
    endcase
  endtask

  initial begin
    bit ok;
    rst      = 1'b1;
    host_req = 1'b0;
    host_cmd = '0;
    int_ack  = 1'b0;
    int0     = 1'b0;
    int1     = 1'b0;
    int2     = 1'b1;
    pb_i     = 8'h00;
    pc_i     = 8'h00;
    build_table();
    repeat (2) @(posedge CLK);
    #1;
    rst = 1'b0;
    ok  = 1'b1;
    for (int i = 0; i < steps.size() && ok; i++) begin
      run_step(steps[i], names[i], ok);
    end
    repeat (2) next_cycle();
    $display("Checks: %0d  Errors: %0d", chk.checks, chk.errors);
    if (ok && chk.errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- filelist.f
+incdir+.
upd_spr_pkg.sv
upd_int_pkg.sv
spr_bus_port.sv
int_sampler.sv
timer_unit.sv
int_controller.sv
port_unit.sv
upd_periph_top.sv
tb_checker.sv
tb_upd_periph.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
  --top-module tb_upd_periph -f filelist.f -o tb_sim

out=$(./obj_dir/tb_sim)
echo "$out"

if echo "$out" | grep -q "^RESULT: PASS$"; then
  exit 0
fi
exit 1
